// File: logic/mcu_pkg.sv
`default_nettype none

package mcu_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [15:0] dptr_t;

   //////////////////////////////////////////////////////////////////////
   // Opcodes kept from the 8051 subset

   typedef enum logic [7:0] {
      OP_DECA   = 8'h14,  // dec a
      OP_JB     = 8'h20,  // jb bit,rel
      OP_XRLA   = 8'h64,  // xrl a,#imm
      OP_MOVAI  = 8'h74,  // mov a,#imm
      OP_SJMP   = 8'h80,  // sjmp rel
      OP_MOVDP  = 8'h90,  // mov dptr,#imm16
      OP_SUBBAI = 8'h94,  // subb a,#imm, no carry in
      OP_MOVXAD = 8'hE0,  // movx a,@dptr
      OP_CLRA   = 8'hE4,  // clr a
      OP_MOVXDA = 8'hF0   // movx @dptr,a
   } opcode_t;

   // Core sequencing
   typedef enum logic [2:0] {
      FETCH,
      OPCODE,
      OPER1,
      OPER2,
      EXECUTE
   } core_state_t;

   //////////////////////////////////////////////////////////////////////
   // Peripheral map on the movx bus

   localparam dptr_t TX_STAT_ADDR = 16'h0200;  // Busy flag in bit 0
   localparam dptr_t TX_DATA_ADDR = 16'h0201;  // Write starts a frame

endpackage

`default_nettype wire

// File: logic/code_load_if.sv
`timescale 1ns/1ps
`default_nettype none

interface code_load_if import mcu_pkg::*; #(
   parameter int CODE_AW = 9
) ();

   logic               wr_en;
   logic [CODE_AW-1:0] wr_addr;
   byte_t              wr_data;
   logic [CODE_AW-1:0] rd_addr;
   byte_t              rd_data;  // One cycle after rd_addr
   logic               loaded;   // Sticky until reset

   modport loader (output wr_en, output wr_addr, output wr_data, output loaded);

   modport ram (
      input  wr_en,
      input  wr_addr,
      input  wr_data,
      input  rd_addr,
      input  loaded,
      output rd_data
   );

   modport core (output rd_addr, input rd_data, input loaded);

endinterface

`default_nettype wire

// File: logic/serial_loader.sv
`timescale 1ns/1ps
`default_nettype none

module serial_loader import mcu_pkg::*; #(
   parameter int BIT_CYCLES = 104,
   parameter int CODE_AW    = 9
) (
   input  wire          i_clk,
   input  wire          i_nrst,
   input  wire          i_uart_rx,
   code_load_if.loader  o_code
);

   localparam int CNT_W = $clog2(BIT_CYCLES);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   rx_state_t          rx_state;
   logic               rx_meta;
   logic               rx_line;
   logic [CNT_W-1:0]   bit_time;
   logic [2:0]         bit_idx;
   byte_t              rx_shift;
   logic [CODE_AW-1:0] load_addr;
   logic               load_done;
   logic               half_tick;
   logic               full_tick;
   logic               byte_done;

   //////////////////////////////////////////////////////////////////////
   // Line resync

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_meta <= 1'b1;  // Idle level
         rx_line <= 1'b1;
      end else begin
         rx_meta <= i_uart_rx;
         rx_line <= rx_meta;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Receive FSM

   assign half_tick = (bit_time == CNT_W'(BIT_CYCLES / 2 - 1));
   assign full_tick = (bit_time == CNT_W'(BIT_CYCLES - 1));
   assign byte_done = (rx_state == RX_STOP) && full_tick;  // Middle of stop bit

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_state <= RX_IDLE;
         bit_time <= '0;
         bit_idx  <= '0;
      end else begin
         case (rx_state)
            RX_IDLE: begin
               bit_time <= '0;
               if (!rx_line && !load_done) rx_state <= RX_START;  // Falling edge while loading
            end
            RX_START: begin
               bit_time <= bit_time + 1'b1;
               if (half_tick) begin
                  bit_time <= '0;
                  bit_idx  <= '0;
                  rx_state <= rx_line ? RX_IDLE : RX_DATA;  // Drop short glitches
               end
            end
            RX_DATA: begin
               bit_time <= bit_time + 1'b1;
               if (full_tick) begin
                  bit_time <= '0;
                  bit_idx  <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) rx_state <= RX_STOP;
               end
            end
            RX_STOP: begin
               bit_time <= bit_time + 1'b1;
               if (full_tick) rx_state <= RX_IDLE;
            end
            default: rx_state <= RX_IDLE;
         endcase
      end
   end

   // LSB arrives first
   always_ff @(posedge i_clk) begin
      if ((rx_state == RX_DATA) && full_tick) rx_shift <= {rx_line, rx_shift[7:1]};
   end

   //////////////////////////////////////////////////////////////////////
   // Code memory fill

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         load_addr <= '0;
         load_done <= 1'b0;
      end else if (o_code.wr_en) begin
         load_addr <= load_addr + 1'b1;
         if (load_addr == '1) load_done <= 1'b1;  // Last byte of the image
      end
   end

   assign o_code.wr_en   = byte_done;
   assign o_code.wr_addr = load_addr;
   assign o_code.wr_data = rx_shift;
   assign o_code.loaded  = load_done;

   // Image frozen for good once loaded
   assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_code.loaded |-> !o_code.wr_en);

endmodule

`default_nettype wire

// File: logic/code_ram.sv
`timescale 1ns/1ps
`default_nettype none

module code_ram import mcu_pkg::*; #(
   parameter int CODE_AW = 9
) (
   input  wire       i_clk,
   code_load_if.ram  o_code
);

   byte_t mem [2**CODE_AW];

   //////////////////////////////////////////////////////////////////////
   // Write port from the loader, registered read for the core

   always_ff @(posedge i_clk) begin
      if (o_code.wr_en) mem[o_code.wr_addr] <= o_code.wr_data;
   end

   always_ff @(posedge i_clk) begin
      o_code.rd_data <= mem[o_code.rd_addr];  // Single cycle latency
   end

   // Core parks on address 0 until the image is complete
   assert property (@(posedge i_clk)
      !o_code.loaded |-> (o_code.rd_addr == '0));

endmodule

`default_nettype wire

// File: logic/mcu_core.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_core import mcu_pkg::*; #(
   parameter int CODE_AW = 9
) (
   input  wire          i_clk,
   input  wire          i_nrst,
   code_load_if.core    o_code,
   input  wire          i_tx_busy,
   output logic         o_tx_start,
   output byte_t        o_tx_byte
);

   core_state_t        state;
   core_state_t        state_next;
   logic [CODE_AW-1:0] pc;
   logic [CODE_AW-1:0] pc_next;
   logic [CODE_AW-1:0] jmp_rel;
   opcode_t            op_q;
   byte_t              oper1_q;
   byte_t              oper2_q;
   byte_t              acc;
   dptr_t              dptr;
   logic               take_jump;

   // Operand bytes that follow an opcode
   function automatic logic [1:0] oper_count(input byte_t op);
      case (op)
         OP_MOVAI, OP_XRLA, OP_SUBBAI, OP_SJMP: oper_count = 2'd1;
         OP_MOVDP, OP_JB:                      oper_count = 2'd2;
         default:                              oper_count = 2'd0;
      endcase
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Sequencing and program counter

   // Offset relative to the next instruction, which pc already holds
   assign jmp_rel   = CODE_AW'($signed((op_q == OP_JB) ? oper2_q : oper1_q));
   assign take_jump = (op_q == OP_SJMP) || ((op_q == OP_JB) && acc[oper1_q[2:0]]);

   always_comb begin
      state_next = state;
      pc_next    = pc;
      case (state)
         FETCH: begin
            if (o_code.loaded) state_next = OPCODE;
         end
         OPCODE: begin
            pc_next    = pc + 1'b1;
            state_next = (oper_count(o_code.rd_data) != 2'd0) ? OPER1 : EXECUTE;
         end
         OPER1: begin
            pc_next    = pc + 1'b1;
            state_next = (oper_count(op_q) == 2'd2) ? OPER2 : EXECUTE;
         end
         OPER2: begin
            pc_next    = pc + 1'b1;
            state_next = EXECUTE;
         end
         EXECUTE: begin
            state_next = OPCODE;  // Next opcode address already on the bus
            if (take_jump) pc_next = pc + jmp_rel;
         end
         default: state_next = FETCH;
      endcase
   end

   assign o_code.rd_addr = pc_next;  // rd_data follows pc one cycle later

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= FETCH;
         pc      <= '0;
         op_q    <= opcode_t'(8'h00);
         oper1_q <= '0;
         oper2_q <= '0;
      end else begin
         state <= state_next;
         pc    <= pc_next;
         case (state)
            OPCODE:  op_q    <= opcode_t'(o_code.rd_data);
            OPER1:   oper1_q <= o_code.rd_data;
            OPER2:   oper2_q <= o_code.rd_data;
            default: ;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Accumulator and data pointer

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc  <= '0;
         dptr <= '0;
      end else if (state == EXECUTE) begin
         case (op_q)
            OP_MOVAI:  acc  <= oper1_q;
            OP_XRLA:   acc  <= acc ^ oper1_q;
            OP_SUBBAI: acc  <= acc - oper1_q;  // Plain subtract
            OP_DECA:   acc  <= acc - 8'd1;
            OP_CLRA:   acc  <= '0;
            OP_MOVDP:  dptr <= {oper1_q, oper2_q};  // High byte first
            OP_MOVXAD: begin
               if (dptr == TX_STAT_ADDR) acc <= {7'd0, i_tx_busy};
            end
            default: ;  // Unknown opcodes do nothing
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Transmit strobe

   // Writes while busy are dropped
   assign o_tx_start = (state == EXECUTE) && (op_q == OP_MOVXDA) &&
                       (dptr == TX_DATA_ADDR) && !i_tx_busy;
   assign o_tx_byte  = acc;

   // Transmitter must take every strobe
   assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_tx_start |=> i_tx_busy);

endmodule

`default_nettype wire

// File: logic/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx import mcu_pkg::*; #(
   parameter int BIT_CYCLES = 104
) (
   input  wire         i_clk,
   input  wire         i_nrst,
   input  wire         i_start,
   input  wire byte_t  i_byte,
   output logic        o_busy,
   output logic        o_uart_tx
);

   localparam int CNT_W = $clog2(BIT_CYCLES);

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_SEND, TX_STOP} tx_state_t;

   tx_state_t        tx_state;
   logic [CNT_W-1:0] bit_time;
   logic [2:0]       bit_idx;
   byte_t            tx_shift;
   logic             bit_end;

   assign bit_end = (bit_time == CNT_W'(BIT_CYCLES - 1));

   //////////////////////////////////////////////////////////////////////
   // Frame FSM

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         tx_state <= TX_IDLE;
         bit_time <= '0;
         bit_idx  <= '0;
      end else begin
         bit_time <= (tx_state == TX_IDLE || bit_end) ? '0 : bit_time + 1'b1;
         case (tx_state)
            TX_IDLE:  if (i_start) tx_state <= TX_START;
            TX_START: begin
               bit_idx <= '0;
               if (bit_end) tx_state <= TX_SEND;
            end
            TX_SEND: begin
               if (bit_end) begin
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) tx_state <= TX_STOP;
               end
            end
            TX_STOP:  if (bit_end) tx_state <= TX_IDLE;  // Busy drops here
            default:  tx_state <= TX_IDLE;
         endcase
      end
   end

   // Latch on start, then shift out LSB first
   always_ff @(posedge i_clk) begin
      if ((tx_state == TX_IDLE) && i_start) tx_shift <= i_byte;
      else if ((tx_state == TX_SEND) && bit_end) tx_shift <= {1'b1, tx_shift[7:1]};
   end

   assign o_busy    = (tx_state != TX_IDLE);
   assign o_uart_tx = (tx_state == TX_START) ? 1'b0 :
                      (tx_state == TX_SEND)  ? tx_shift[0] :
                                               1'b1;  // Idle and stop are high

endmodule

`default_nettype wire

// File: logic/mcu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_top import mcu_pkg::*; #(
   parameter int BIT_CYCLES = 104,
   parameter int CODE_AW    = 9
) (
   input  wire  i_clk,
   input  wire  i_nrst,
   input  wire  i_uart_rx,
   output wire  o_uart_tx
);

   logic  tx_start;
   byte_t tx_byte;
   logic  tx_busy;

   code_load_if #(.CODE_AW(CODE_AW)) code_bus ();

   //////////////////////////////////////////////////////////////////////
   // Loader, code memory, core and transmitter

   serial_loader #(.BIT_CYCLES(BIT_CYCLES), .CODE_AW(CODE_AW)) u_loader (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_uart_rx (i_uart_rx),
      .o_code    (code_bus)
   );

   code_ram #(.CODE_AW(CODE_AW)) u_ram (
      .i_clk  (i_clk),
      .o_code (code_bus)
   );

   mcu_core #(.CODE_AW(CODE_AW)) u_core (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .o_code     (code_bus),
      .i_tx_busy  (tx_busy),
      .o_tx_start (tx_start),
      .o_tx_byte  (tx_byte)
   );

   uart_tx #(.BIT_CYCLES(BIT_CYCLES)) u_tx (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_start   (tx_start),
      .i_byte    (tx_byte),
      .o_busy    (tx_busy),
      .o_uart_tx (o_uart_tx)
   );

endmodule

`default_nettype wire

// File: verif/tb_mcu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mcu import mcu_pkg::*; ();

   localparam int BIT_CYCLES = 8;
   localparam int CODE_AW    = 5;
   localparam int CODE_N     = 2**CODE_AW;  // One load is 32 bytes
   localparam int FRAME      = 10 * BIT_CYCLES;
   localparam int MARGIN     = 4000;        // Covers the delay loops of the counting program

   logic        i_clk;
   logic        i_nrst;
   logic        i_uart_rx;
   wire         o_uart_tx;

   byte_t       prog [CODE_N];
   int          wp;
   byte_t       exp_q [$];
   byte_t       rx_q [$];
   int          n_checked = 0;
   logic        loading = 1'b0;
   longint      cycles = 0;
   longint      limit = 1000;
   logic [15:0] lfsr_q = 16'd1614;

   mcu_top #(.BIT_CYCLES(BIT_CYCLES), .CODE_AW(CODE_AW)) dut (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_uart_rx (i_uart_rx),
      .o_uart_tx (o_uart_tx)
   );

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Failure handling and compares

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "Simulation stopped at %0t", $time);
   endtask

   task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
      if (got !== exp)
         fail_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         fail_run($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, exp));
   endtask

   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (cycles > limit) fail_run("Timeout: the expected bytes did not arrive on o_uart_tx");
   end

   // Nothing may leave the transmitter before the image is complete
   always @(negedge i_clk) begin
      if (loading && o_uart_tx !== 1'b1)
         fail_run("o_uart_tx left its idle level before all code bytes were sent");
   end

   //////////////////////////////////////////////////////////////////////
   // Random immediates, Fibonacci LFSR x^16+x^14+x^13+x^11

   function automatic byte_t rand_byte();
      byte_t b;
      logic  fb;
      b = '0;
      for (int i = 0; i < 8; i++) begin
         fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
         lfsr_q = {lfsr_q[14:0], fb};
         b      = {b[6:0], fb};
      end
      return b;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Program image assembly

   task automatic clear_image();
      for (int a = 0; a < CODE_N; a++) prog[a] = 8'hA0 ^ byte_t'(a);  // Never reached
      wp = 0;
   endtask

   task automatic emit(input byte_t b);
      prog[wp] = b;
      wp++;
   endtask

   task automatic emit_dptr(input dptr_t v);
      emit(OP_MOVDP);
      emit(v[15:8]);
      emit(v[7:0]);
   endtask

   task automatic emit_jb(input int bitn, input int target);
      byte_t rel;
      rel = byte_t'(target - (wp + 3));  // From the next instruction
      emit(OP_JB);
      emit(8'hE0 | byte_t'(bitn));
      emit(rel);
   endtask

   // Spin while the busy flag is set, leaves a at zero
   task automatic emit_poll();
      int loop_at;
      emit_dptr(TX_STAT_ADDR);
      loop_at = wp;
      emit(OP_MOVXAD);
      emit_jb(0, loop_at);
   endtask

   task automatic emit_send();
      emit_dptr(TX_DATA_ADDR);
      emit(OP_MOVXDA);
   endtask

   task automatic emit_halt();
      emit(OP_SJMP);
      emit(8'hFE);
   endtask

   // Each pass sends a, then decrements 32 times, well past one frame
   task automatic build_count_loop();
      int send_at;
      int dec_at;
      clear_image();
      emit_dptr(TX_DATA_ADDR);
      emit(OP_MOVAI);
      emit(8'hE0);
      send_at = wp;
      emit(OP_MOVXDA);
      dec_at = wp;
      emit(OP_DECA);
      for (int b = 0; b < 5; b++) emit_jb(b, dec_at);  // Until the low 5 bits are zero
      emit_jb(7, send_at);
      emit_halt();
   endtask

   //////////////////////////////////////////////////////////////////////
   // Reference model, busy flag always reads 0

   function automatic bit run_reference();
      int    pc;
      int    nxt;
      int    len;
      int    steps;
      byte_t acc;
      byte_t op;
      byte_t o1;
      byte_t o2;
      dptr_t dp;
      pc  = 0;
      acc = '0;
      dp  = '0;
      for (steps = 0; steps < 4096; steps++) begin
         op  = prog[pc];
         o1  = prog[(pc + 1) % CODE_N];
         o2  = prog[(pc + 2) % CODE_N];
         len = 1;
         if (op == OP_MOVAI || op == OP_XRLA || op == OP_SUBBAI || op == OP_SJMP) len = 2;
         if (op == OP_MOVDP || op == OP_JB) len = 3;
         nxt = (pc + len) % CODE_N;
         case (op)
            OP_MOVAI:  acc = o1;
            OP_XRLA:   acc = acc ^ o1;
            OP_SUBBAI: acc = acc - o1;
            OP_DECA:   acc = acc - 8'd1;
            OP_CLRA:   acc = 8'h00;
            OP_MOVDP:  dp = {o1, o2};
            OP_MOVXAD: if (dp == TX_STAT_ADDR) acc = 8'h00;
            OP_MOVXDA: if (dp == TX_DATA_ADDR) exp_q.push_back(acc);
            OP_JB:     if (acc[o1[2:0]]) nxt = (nxt + int'($signed(o2))) & (CODE_N - 1);
            OP_SJMP: begin
               if (o1 == 8'hFE) return 1'b1;  // Halt loop
               nxt = (nxt + int'($signed(o1))) & (CODE_N - 1);
            end
            default: ;
         endcase
         pc = nxt;
      end
      return 1'b0;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Serial driver, monitor and compare

   task automatic send_byte(input byte_t b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};  // Start, LSB first data, stop
      for (int i = 0; i < 10; i++) begin
         @(posedge i_clk);
         #1;
         i_uart_rx = frame[i];
         repeat (BIT_CYCLES - 1) @(posedge i_clk);
      end
   endtask

   initial begin : serial_monitor
      byte_t data;
      forever begin
         @(negedge i_clk);
         if (o_uart_tx === 1'b0) begin
            repeat (BIT_CYCLES / 2 - 1) @(negedge i_clk);  // Middle of start bit
            compare_bit("o_uart_tx start bit", o_uart_tx, 1'b0);
            for (int i = 0; i < 8; i++) begin
               repeat (BIT_CYCLES) @(negedge i_clk);
               data[i] = o_uart_tx;
            end
            repeat (BIT_CYCLES) @(negedge i_clk);
            compare_bit("o_uart_tx stop bit", o_uart_tx, 1'b1);
            rx_q.push_back(data);
         end
      end
   end

   initial begin : byte_compare
      byte_t got;
      forever begin
         @(negedge i_clk);
         while (rx_q.size() > 0) begin
            got = rx_q.pop_front();
            if (exp_q.size() == 0) fail_run("A byte arrived on o_uart_tx that was not expected");
            compare_byte("o_uart_tx data", got, exp_q.pop_front());
            n_checked++;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Program runs

   task automatic reset_dut();
      @(posedge i_clk);
      #1;
      i_nrst    = 1'b0;
      i_uart_rx = 1'b1;
      repeat (8) @(posedge i_clk);
      #1;
      i_nrst = 1'b1;
   endtask

   task automatic run_program(input string name, input int extra);
      int n_exp;
      exp_q.delete();
      n_checked = 0;
      if (!run_reference()) fail_run({name, ": program never reaches its halt loop"});
      n_exp = exp_q.size();
      limit = cycles + (CODE_N + extra + 2 * n_exp + 4) * FRAME + MARGIN;
      reset_dut();
      loading = 1'b1;
      repeat (2 * BIT_CYCLES) @(posedge i_clk);  // Idle line after reset
      for (int i = 0; i < CODE_N; i++) begin
         if (i == CODE_N - 1) loading = 1'b0;
         send_byte(prog[i]);
      end
      fork
         begin
            for (int i = 0; i < extra; i++) send_byte(rand_byte());  // Loader must ignore these
         end
         while (n_checked < n_exp) @(posedge i_clk);
      join
      repeat (2 * FRAME) @(posedge i_clk);  // Stray frames would show up here
      $display("%s: %0d bytes checked", name, n_checked);
   endtask

   initial begin
      i_nrst    = 1'b0;
      i_uart_rx = 1'b1;

      // Single send of an immediate
      clear_image();
      emit_poll();
      emit(OP_MOVAI);
      emit(rand_byte());
      emit_send();
      emit_halt();
      run_program("single send", 0);

      // Arithmetic chain, xrl and clr act on a nonzero accumulator
      clear_image();
      emit(OP_XRLA);
      emit(rand_byte());
      emit(OP_SUBBAI);
      emit(rand_byte());
      emit(OP_XRLA);
      emit(rand_byte());
      emit_send();
      emit_poll();
      emit(OP_XRLA);
      emit(rand_byte());
      emit(OP_CLRA);
      emit(OP_SUBBAI);
      emit(rand_byte());
      emit(OP_DECA);
      emit_send();
      emit_halt();
      run_program("arithmetic chain", 0);

      build_count_loop();
      run_program("counting loop", 0);

      build_count_loop();
      run_program("counting loop with extra serial bytes", 6);

      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
logic/mcu_pkg.sv
logic/code_load_if.sv
logic/serial_loader.sv
logic/code_ram.sv
logic/mcu_core.sv
logic/uart_tx.sv
logic/mcu_top.sv
verif/tb_mcu.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mcu -f vlog.f > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_mcu > sim.log 2>&1 || true
cat sim.log

! grep -q "Test failed" sim.log && grep -q "Test passed" sim.log && exit 0 || exit 1
